// ==== project.f ====
+incdir+verilog
verilog/scdCtlPkg.sv
verilog/scdFlagPkg.sv
verilog/scadOperandMux.sv
verilog/scadAlu.sv
verilog/feScRegs.sv
verilog/pcFlags.sv
verilog/scdTop.sv
dv/scdTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= scdTb
RTL_TOP   ?= scdTop
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/scdTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module scdTb import scdCtlPkg::*, scdFlagPkg::*; ();

  localparam int resetCycles    = 10;
  localparam int directedCycles = 310;
  localparam int randomCycles   = 1000;
  localparam int cycleLimit     = 2 * (resetCycles + directedCycles + randomCycles);

  localparam logic [0:`AR_WIDTH-1] posAr = 36'h1_2345_6789;
  localparam logic [0:`AR_WIDTH-1] negAr = 36'hC_B7E1_5A3D;

  logic                    clk;
  logic                    arstN;
  scadFuncE                scadFunc;
  scadaSelE                scadaSel;
  scadbSelE                scadbSel;
  scmSelE                  scmSel;
  logic [0:`MAGIC_WIDTH-1] magic;
  logic                    feLoad;
  logic                    feShift;
  logic                    loadFlags;
  logic                    setAdFlags;
  logic                    pcfMagic;
  logic                    expTest;
  logic                    nicondDisp;
  logic                    piCycle;
  logic                    trapEn;
  logic [0:`AR_WIDTH-1]    ar;
  logic                    adOverflow;
  logic                    adCry0;
  logic                    adCry1;
  logic [0:`SCD_WIDTH-1]   scad;
  logic                    scadSign;
  logic                    scadZero;
  logic [0:`SCD_WIDTH-1]   fe;
  logic [0:`SCD_WIDTH-1]   sc;
  logic                    scGe36;
  logic                    sc36To63;
  pcFlagsS                 flags;
  logic                    trapPending;

  // Reference state runs one cycle ahead of what the DUT registers show
  logic [0:`SCD_WIDTH-1]   refFe;
  logic [0:`SCD_WIDTH-1]   refSc;
  pcFlagsS                 refFlags;
  int                      cycleCount = 0;

  scdTop dut_i (
    .clk(clk), .arstN(arstN), .scadFunc(scadFunc), .scadaSel(scadaSel),
    .scadbSel(scadbSel), .scmSel(scmSel), .magic(magic), .feLoad(feLoad),
    .feShift(feShift), .loadFlags(loadFlags), .setAdFlags(setAdFlags),
    .pcfMagic(pcfMagic), .expTest(expTest), .nicondDisp(nicondDisp),
    .piCycle(piCycle), .trapEn(trapEn), .ar(ar), .adOverflow(adOverflow),
    .adCry0(adCry0), .adCry1(adCry1), .scad(scad), .scadSign(scadSign),
    .scadZero(scadZero), .fe(fe), .sc(sc), .scGe36(scGe36), .sc36To63(sc36To63),
    .flags(flags), .trapPending(trapPending)
  );

  always #50 clk = ~clk;

  // Result is the sign bit followed by the ten SCAD bits
  function automatic logic [0:`SCD_WIDTH] refScad(
    input logic [2:0] fn, input logic [2:0] aSel, input logic [1:0] bSel,
    input logic [0:`MAGIC_WIDTH-1] m, input logic [0:`SCD_WIDTH-1] feVal,
    input logic [0:`SCD_WIDTH-1] scVal, input logic [0:`AR_WIDTH-1] arVal);
    logic [0:`SCD_WIDTH-1] opA;
    logic [0:`SCD_WIDTH-1] opB;
    logic [0:`SCD_WIDTH-1] magicVal;
    int a;
    int b;
    int r;
    magicVal = {m[0], m};
    case (aSel)
      3'd0:    opA = feVal;
      3'd1:    opA = {4'b0, arVal[0:5]};
      3'd2:    opA = {2'b0, arVal[1:8] ^ {8{arVal[0]}}};
      3'd3:    opA = magicVal;
      default: opA = '0;
    endcase
    case (bSel)
      2'd0:    opB = scVal;
      2'd1:    opB = {4'b0, arVal[6:11]};
      2'd2:    opB = {1'b0, arVal[0:8]};
      default: opB = magicVal;
    endcase
    a = int'($signed(opA));
    b = int'($signed(opB));
    case (fn)
      3'd0:    r = a;
      3'd1:    r = a - b - 1;
      3'd2:    r = a + b;
      3'd3:    r = a - 1;
      3'd4:    r = a + 1;
      3'd5:    r = a - b;
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r[10:0];
  endfunction

  function automatic pcFlagsS refNextFlags(input pcFlagsS cur,
                                           input logic [0:`SCD_WIDTH-1] scadVal);
    pcFlagsS nxt;
    logic    setAd;
    logic    pcfM;
    logic    expT;
    logic    ovEvent;
    logic    fovEvent;
    nxt   = cur;
    setAd = setAdFlags && !piCycle;
    pcfM  = pcfMagic && !piCycle;
    expT  = expTest && !piCycle;
    if (loadFlags) begin
      nxt.ov       = ar[0];
      nxt.cry0     = ar[1];
      nxt.cry1     = ar[2];
      nxt.fov      = ar[3];
      nxt.fpd      = ar[4];
      nxt.trapReq2 = ar[9];
      nxt.trapReq1 = ar[10];
      nxt.fxu      = ar[11];
      nxt.divChk   = ar[12];
    end else begin
      fovEvent = (expT && scadVal[1]) || (pcfM && magic[0]);
      ovEvent  = fovEvent || (setAd && adOverflow);
      if (ovEvent) nxt.ov = 1'b1;
      if (fovEvent) nxt.fov = 1'b1;
      if (setAd && adCry0) nxt.cry0 = 1'b1;
      if (setAd && adCry1) nxt.cry1 = 1'b1;
      if ((expT && scadVal[0]) || (pcfM && magic[5])) nxt.fxu = 1'b1;
      if (pcfM && magic[6]) nxt.divChk = 1'b1;
      if (pcfM && magic[2]) nxt.fpd = 1'b1;
      if (nicondDisp) begin
        nxt.trapReq1 = 1'b0;
        nxt.trapReq2 = 1'b0;
      end
      if (ovEvent || (pcfM && magic[4])) nxt.trapReq1 = 1'b1;
      if (pcfM && magic[3]) nxt.trapReq2 = 1'b1;
    end
    return nxt;
  endfunction

  task automatic checkValue(input string name, input logic [35:0] got,
                            input logic [35:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      $display("CHECKS FAILED");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Outputs are settled mid-cycle, and inputs hold until after the next edge
  always @(negedge clk) begin : compareOutputs
    logic [0:`SCD_WIDTH]   expScad;
    logic [0:`SCD_WIDTH-1] expVal;
    // The DUT registers clear as soon as reset goes low
    if (!arstN) begin
      refFe    = '0;
      refSc    = '0;
      refFlags = '0;
    end
    expScad = refScad(scadFunc, scadaSel, scadbSel, magic, refFe, refSc, ar);
    expVal  = expScad[1:`SCD_WIDTH];
    checkValue("scad", 36'(scad), 36'(expVal));
    checkValue("scadSign", 36'(scadSign), 36'(expScad[0]));
    checkValue("scadZero", 36'(scadZero), 36'(expVal == '0));
    checkValue("fe", 36'(fe), 36'(refFe));
    checkValue("sc", 36'(sc), 36'(refSc));
    checkValue("scGe36", 36'(scGe36), 36'(refSc >= 64));
    checkValue("sc36To63", 36'(sc36To63), 36'((refSc % 64) >= 36));
    checkValue("flags", 36'(flags), 36'(refFlags));
    checkValue("trapPending", 36'(trapPending),
               36'((refFlags.trapReq1 || refFlags.trapReq2) && trapEn));
    if (arstN) begin
      refFlags = refNextFlags(refFlags, expVal);
      case (scmSel)
        scmFe:   refSc = refFe;
        scmScad: refSc = expVal;
        scmAr:   refSc = {ar[18], ar[18], ar[28:35]};
        default: refSc = refSc;
      endcase
      if (feLoad) begin
        refFe = expVal;
      end else if (feShift) begin
        refFe = $signed(refFe) >>> 1;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
      $display("CHECKS FAILED");
      $fatal(1, "Timeout");
    end
  end

  task automatic idleInputs();
    scadFunc   = fnA;
    scadaSel   = selaFe;
    scadbSel   = selbSc;
    scmSel     = scmHold;
    magic      = '0;
    feLoad     = 1'b0;
    feShift    = 1'b0;
    loadFlags  = 1'b0;
    setAdFlags = 1'b0;
    pcfMagic   = 1'b0;
    expTest    = 1'b0;
    nicondDisp = 1'b0;
    piCycle    = 1'b0;
    trapEn     = 1'b0;
    ar         = '0;
    adOverflow = 1'b0;
    adCry0     = 1'b0;
    adCry1     = 1'b0;
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #5;
    idleInputs();
  endtask

  task automatic selectMagicResult(input logic [0:`MAGIC_WIDTH-1] value);
    scadFunc = fnA;
    scadaSel = selaMagic;
    magic    = value;
  endtask

  // Control bits in order are load setAd pcfMagic expTest nicond piCycle trapEn adOv
  // adCry0 adCry1
  task automatic flagStep(input logic [0:9] ctl, input logic [0:`MAGIC_WIDTH-1] m,
                          input logic [0:`AR_WIDTH-1] arVal);
    nextCycle();
    scadFunc   = fnAPlusB;
    scadaSel   = selaMagic;
    scadbSel   = selbMagic;
    magic      = m;
    ar         = arVal;
    loadFlags  = ctl[0];
    setAdFlags = ctl[1];
    pcfMagic   = ctl[2];
    expTest    = ctl[3];
    nicondDisp = ctl[4];
    piCycle    = ctl[5];
    trapEn     = ctl[6];
    adOverflow = ctl[7];
    adCry0     = ctl[8];
    adCry1     = ctl[9];
  endtask

  task automatic checkAfterReset();
    trapEn = 1'b1;
    #1;
    checkValue("fe", 36'(fe), 36'd0);
    checkValue("sc", 36'(sc), 36'd0);
    checkValue("flags", 36'(flags), 36'd0);
    checkValue("trapPending", 36'(trapPending), 36'd0);
  endtask

  task automatic runScadSweep();
    nextCycle();
    selectMagicResult(9'h0A7);
    feLoad = 1'b1;
    nextCycle();
    selectMagicResult(9'h1C9);
    scmSel = scmScad;
    for (int fn = 0; fn < 8; fn++) begin
      for (int aSel = 0; aSel < 8; aSel++) begin
        for (int bSel = 0; bSel < 4; bSel++) begin
          nextCycle();
          scadFunc = scadFuncE'(fn[2:0]);
          scadaSel = scadaSelE'(aSel[2:0]);
          scadbSel = scadbSelE'(bSel[1:0]);
          ar       = bSel[0] ? negAr : posAr;
          magic    = bSel[1] ? 9'h1A6 : 9'h05B;
        end
      end
    end
  endtask

  task automatic runFeScTests();
    int rangeValues[4] = '{35, 36, 63, 64};
    nextCycle();
    selectMagicResult(9'h1F3);
    feLoad = 1'b1;
    repeat (3) begin
      nextCycle();
      feShift = 1'b1;
    end
    repeat (2) nextCycle();
    nextCycle();
    selectMagicResult(9'h064);
    feLoad  = 1'b1;
    feShift = 1'b1;
    nextCycle();
    feShift = 1'b1;
    nextCycle();
    scmSel = scmFe;
    nextCycle();
    scadFunc = fnAPlus1;
    scmSel   = scmScad;
    nextCycle();
    ar     = 36'h0_0002_00A5;
    scmSel = scmAr;
    nextCycle();
    ar     = 36'h0_0000_005A;
    scmSel = scmAr;
    repeat (2) nextCycle();
    for (int i = 0; i < 4; i++) begin
      nextCycle();
      selectMagicResult(9'(rangeValues[i]));
      scmSel = scmScad;
      nextCycle();
    end
  endtask

  task automatic runFlagTests();
    flagStep(10'b1000000000, 9'h000, '1);
    flagStep(10'b1000000000, 9'h000, 36'hA_5A5A_5A5A);
    flagStep(10'b1000000000, 9'h000, '0);
    flagStep(10'b0100011111, 9'h000, '0);
    flagStep(10'b0100001110, 9'h000, '0);
    flagStep(10'b0100000001, 9'h000, '0);
    flagStep(10'b1000000000, 9'h000, '0);
    // Doubled magic gives SCAD bit 1 alone, then bit 0 alone
    flagStep(10'b0001010000, 9'h0FF, '0);
    flagStep(10'b0001000000, 9'h0FF, '0);
    flagStep(10'b0001000000, 9'h100, '0);
    flagStep(10'b0010010000, 9'h1FF, '0);
    flagStep(10'b0010000000, 9'h1FF, '0);
    flagStep(10'b0000001000, 9'h000, '0);
    flagStep(10'b0000101000, 9'h000, '0);
  endtask

  task automatic runTrapTests();
    flagStep(10'b1000000000, 9'h000, '0);
    flagStep(10'b0010001000, 9'h020, '0);
    flagStep(10'b0000001000, 9'h000, '0);
    flagStep(10'b0000000000, 9'h000, '0);
    flagStep(10'b0010101000, 9'h010, '0);
    flagStep(10'b0000001000, 9'h000, '0);
    flagStep(10'b0000101000, 9'h000, '0);
    flagStep(10'b0100011100, 9'h000, '0);
    flagStep(10'b0100001100, 9'h000, '0);
    flagStep(10'b0000101000, 9'h000, '0);
    flagStep(10'b1000001000, 9'h000, 36'h0_0600_0000);
    flagStep(10'b0000001000, 9'h000, '0);
  endtask

  task automatic runRandom();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    for (int i = 0; i < randomCycles; i++) begin
      nextCycle();
      r1 = $urandom();
      r2 = $urandom();
      r3 = $urandom();
      ar         = {r1, r2[3:0]};
      scadFunc   = scadFuncE'(r2[6:4]);
      scadaSel   = scadaSelE'(r2[9:7]);
      scadbSel   = scadbSelE'(r2[11:10]);
      scmSel     = scmSelE'(r2[13:12]);
      magic      = r2[22:14];
      feLoad     = r2[23];
      feShift    = r2[24];
      loadFlags  = (r3[2:0] == 3'd0);
      setAdFlags = r3[3];
      pcfMagic   = r3[4] & r3[5];
      expTest    = r3[6];
      nicondDisp = (r3[8:7] == 2'd0);
      piCycle    = (r3[10:9] == 2'd0);
      trapEn     = r3[11];
      adOverflow = r3[12] & r3[13];
      adCry0     = r3[14];
      adCry1     = r3[15];
    end
  endtask

  initial begin
    void'($urandom(32'h231c_d443));
    clk   = 1'b0;
    arstN = 1'b0;
    idleInputs();
    repeat (resetCycles) @(posedge clk);
    #5;
    arstN = 1'b1;
    checkAfterReset();
    runScadSweep();
    runFeScTests();
    runFlagTests();
    runTrapTests();
    runRandom();
    nextCycle();
    @(negedge clk);
    #1;
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/scdTop.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module scdTop import scdCtlPkg::*, scdFlagPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  scadFuncE                scadFunc,
  input  scadaSelE                scadaSel,
  input  scadbSelE                scadbSel,
  input  scmSelE                  scmSel,
  input  magicU                   magic,
  input  logic                    feLoad,
  input  logic                    feShift,
  input  logic                    loadFlags,
  input  logic                    setAdFlags,
  input  logic                    pcfMagic,
  input  logic                    expTest,
  input  logic                    nicondDisp,
  input  logic                    piCycle,
  input  logic                    trapEn,
  input  logic [0:`AR_WIDTH-1]    ar,
  input  logic                    adOverflow,
  input  logic                    adCry0,
  input  logic                    adCry1,
  output logic [0:`SCD_WIDTH-1]   scad,
  output logic                    scadSign,
  output logic                    scadZero,
  output logic [0:`SCD_WIDTH-1]   fe,
  output logic [0:`SCD_WIDTH-1]   sc,
  output logic                    scGe36,
  output logic                    sc36To63,
  output pcFlagsS                 flags,
  output logic                    trapPending
);

  logic [0:`SCD_WIDTH-1] scadA;
  logic [0:`SCD_WIDTH-1] scadB;

  scadOperandMux uOperandMux (
    .scadaSel(scadaSel), .scadbSel(scadbSel), .magic(magic),
    .fe(fe), .sc(sc), .ar(ar), .scadA(scadA), .scadB(scadB)
  );

  scadAlu uAlu (
    .scadFunc(scadFunc), .scadA(scadA), .scadB(scadB),
    .scad(scad), .scadSign(scadSign), .scadZero(scadZero)
  );

  feScRegs uFeSc (
    .clk(clk), .arstN(arstN), .scad(scad), .ar(ar),
    .feLoad(feLoad), .feShift(feShift), .scmSel(scmSel),
    .fe(fe), .sc(sc), .scGe36(scGe36), .sc36To63(sc36To63)
  );

  pcFlags uFlags (
    .clk(clk), .arstN(arstN), .ar(ar), .scad(scad), .magic(magic),
    .loadFlags(loadFlags), .setAdFlags(setAdFlags), .pcfMagic(pcfMagic),
    .expTest(expTest), .piCycle(piCycle), .adOverflow(adOverflow),
    .adCry0(adCry0), .adCry1(adCry1), .nicondDisp(nicondDisp),
    .trapEn(trapEn), .flags(flags), .trapPending(trapPending)
  );

endmodule

`default_nettype wire

// ==== verilog/pcFlags.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module pcFlags import scdCtlPkg::*, scdFlagPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic [0:`AR_WIDTH-1]    ar,
  input  logic [0:`SCD_WIDTH-1]   scad,
  input  magicU                   magic,
  input  logic                    loadFlags,
  input  logic                    setAdFlags,
  input  logic                    pcfMagic,
  input  logic                    expTest,
  input  logic                    piCycle,
  input  logic                    adOverflow,
  input  logic                    adCry0,
  input  logic                    adCry1,
  input  logic                    nicondDisp,
  input  logic                    trapEn,
  output pcFlagsS                 flags,
  output logic                    trapPending
);

  logic setAd;
  logic pcfM;
  logic expT;
  logic ovSet;
  logic fovSet;
  logic trap1Set;
  logic trap2Set;

  // Flag updates are held off during a PI cycle
  assign setAd = setAdFlags & ~piCycle;
  assign pcfM  = pcfMagic & ~piCycle;
  assign expT  = expTest & ~piCycle;

  // Exponent test looks at SCAD bit 1 for overflow and bit 0 for underflow
  assign fovSet   = (expT & scad[1]) | (pcfM & magic.mask.ov);
  assign ovSet    = (setAd & adOverflow) | fovSet;
  assign trap1Set = ovSet | (pcfM & magic.mask.trap1);
  assign trap2Set = pcfM & magic.mask.trap2;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (loadFlags) begin
      flags.ov       <= ar[0];
      flags.cry0     <= ar[1];
      flags.cry1     <= ar[2];
      flags.fov      <= ar[3];
      flags.fpd      <= ar[4];
      flags.trapReq2 <= ar[9];
      flags.trapReq1 <= ar[10];
      flags.fxu      <= ar[11];
      flags.divChk   <= ar[12];
    end else begin
      flags.ov     <= flags.ov | ovSet;
      flags.fov    <= flags.fov | fovSet;
      flags.cry0   <= flags.cry0 | (setAd & adCry0);
      flags.cry1   <= flags.cry1 | (setAd & adCry1);
      flags.fxu    <= flags.fxu | (expT & scad[0]) | (pcfM & magic.mask.fxu);
      flags.divChk <= flags.divChk | (pcfM & magic.mask.divChk);
      flags.fpd    <= flags.fpd | (pcfM & magic.mask.fpd);
      // A new request in the dispatch cycle survives the clear
      flags.trapReq1 <= trap1Set | (flags.trapReq1 & ~nicondDisp);
      flags.trapReq2 <= trap2Set | (flags.trapReq2 & ~nicondDisp);
    end
  end

  assign trapPending = (flags.trapReq1 | flags.trapReq2) & trapEn;

  flagsQuiet: assert property (@(posedge clk) disable iff (!arstN)
    !(loadFlags | setAdFlags | pcfMagic | expTest | nicondDisp) |=> $stable(flags));

endmodule

`default_nettype wire

// ==== verilog/feScRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module feScRegs import scdCtlPkg::*; (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic [0:`SCD_WIDTH-1]   scad,
  input  logic [0:`AR_WIDTH-1]    ar,
  input  logic                    feLoad,
  input  logic                    feShift,
  input  scmSelE                  scmSel,
  output logic [0:`SCD_WIDTH-1]   fe,
  output logic [0:`SCD_WIDTH-1]   sc,
  output logic                    scGe36,
  output logic                    sc36To63
);

  logic [0:`SCD_WIDTH-1] scm;

  // Load wins over shift; the sign bit is copied in on a shift
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fe <= '0;
    end else if (feLoad) begin
      fe <= scad;
    end else if (feShift) begin
      fe <= {fe[0], fe[0:`SCD_WIDTH-2]};
    end
  end

  always_comb begin
    case (scmSel)
      scmHold: scm = sc;
      scmFe:   scm = fe;
      scmScad: scm = scad;
      default: scm = {ar[18], ar[18], ar[28:35]};
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sc <= '0;
    end else begin
      sc <= scm;
    end
  end

  // Range tests used by the shift and byte microcode
  assign scGe36   = |sc[0:3];
  assign sc36To63 = sc[4] & (|sc[5:7]);

  // FE must stay defined once out of reset whatever the microcode does
  feKnown: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(fe));

endmodule

`default_nettype wire

// ==== verilog/scadAlu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module scadAlu import scdCtlPkg::*; (
  input  scadFuncE                scadFunc,
  input  logic [0:`SCD_WIDTH-1]   scadA,
  input  logic [0:`SCD_WIDTH-1]   scadB,
  output logic [0:`SCD_WIDTH-1]   scad,
  output logic                    scadSign,
  output logic                    scadZero
);

  logic [0:`SCD_WIDTH] aExt;
  logic [0:`SCD_WIDTH] bExt;
  logic [0:`SCD_WIDTH] result;

  // One extra sign bit above the ten result bits
  assign aExt = {scadA[0], scadA};
  assign bExt = {scadB[0], scadB};

  always_comb begin
    case (scadFunc)
      fnA:             result = aExt;
      fnAMinusBMinus1: result = aExt + ~bExt;
      fnAPlusB:        result = aExt + bExt;
      fnAMinus1:       result = aExt - 1'b1;
      fnAPlus1:        result = aExt + 1'b1;
      fnAMinusB:       result = aExt - bExt;
      fnOr:            result = aExt | bExt;
      default:         result = aExt & bExt;
    endcase
  end

  assign scadSign = result[0];
  assign scad     = result[1:`SCD_WIDTH];

  // Zero test ignores the extension bit
  assign scadZero = (scad == '0);

endmodule

`default_nettype wire

// ==== verilog/scadOperandMux.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "scd_cfg.svh"

module scadOperandMux import scdCtlPkg::*; (
  input  scadaSelE                scadaSel,
  input  scadbSelE                scadbSel,
  input  magicU                   magic,
  input  logic [0:`SCD_WIDTH-1]   fe,
  input  logic [0:`SCD_WIDTH-1]   sc,
  input  logic [0:`AR_WIDTH-1]    ar,
  output logic [0:`SCD_WIDTH-1]   scadA,
  output logic [0:`SCD_WIDTH-1]   scadB
);

  logic [0:7]              expFold;
  logic [0:`SCD_WIDTH-1]   magicExt;

  // Exponent of a negative number is stored ones-complemented
  assign expFold = ar[1:8] ^ {8{ar[0]}};

  assign magicExt = {{(`SCD_WIDTH - `MAGIC_WIDTH){magic.value[0]}}, magic.value};

  always_comb begin
    case (scadaSel)
      selaFe: begin
        scadA = fe;
      end
      selaArPos: begin
        scadA = {{(`SCD_WIDTH - 6){1'b0}}, ar[0:5]};
      end
      selaExp: begin
        scadA = {{(`SCD_WIDTH - 8){1'b0}}, expFold};
      end
      selaMagic: begin
        scadA = magicExt;
      end
      default: begin
        scadA = '0;
      end
    endcase
  end

  always_comb begin
    case (scadbSel)
      selbSc:    scadB = sc;
      selbArPos: scadB = {{(`SCD_WIDTH - 6){1'b0}}, ar[6:11]};
      selbArExp: scadB = {{(`SCD_WIDTH - 9){1'b0}}, ar[0:8]};
      default:   scadB = magicExt;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/scdFlagPkg.sv ====
`default_nettype none

package scdFlagPkg;

  // Arithmetic PC flags and the two pending trap requests
  typedef struct packed {
    logic ov;
    logic cry0;
    logic cry1;
    logic fov;
    logic fxu;
    logic divChk;
    logic fpd;
    logic trapReq1;
    logic trapReq2;
  } pcFlagsS;

endpackage

`default_nettype wire

// ==== verilog/scdCtlPkg.sv ====
`default_nettype none

`include "scd_cfg.svh"

package scdCtlPkg;

  // SCAD function as coded in the microword
  typedef enum logic [2:0] {
    fnA             = 3'd0,
    fnAMinusBMinus1 = 3'd1,
    fnAPlusB        = 3'd2,
    fnAMinus1       = 3'd3,
    fnAPlus1        = 3'd4,
    fnAMinusB       = 3'd5,
    fnOr            = 3'd6,
    fnAnd           = 3'd7
  } scadFuncE;

  // Codes 4 to 7 give a zero A operand
  typedef enum logic [2:0] {
    selaFe    = 3'd0,
    selaArPos = 3'd1,
    selaExp   = 3'd2,
    selaMagic = 3'd3
  } scadaSelE;

  typedef enum logic [1:0] {
    selbSc    = 2'd0,
    selbArPos = 2'd1,
    selbArExp = 2'd2,
    selbMagic = 2'd3
  } scadbSelE;

  typedef enum logic [1:0] {
    scmHold = 2'd0,
    scmFe   = 2'd1,
    scmScad = 2'd2,
    scmAr   = 2'd3
  } scmSelE;

  // Magic field seen as a flag set mask with bit 0 first
  typedef struct packed {
    logic       ov;
    logic       spare1;
    logic       fpd;
    logic       trap2;
    logic       trap1;
    logic       fxu;
    logic       divChk;
    logic [1:0] spare78;
  } magicMaskS;

  typedef union packed {
    logic [0:`MAGIC_WIDTH-1] value;
    magicMaskS               mask;
  } magicU;

endpackage

`default_nettype wire

// ==== verilog/scd_cfg.svh ====
`ifndef SCD_CFG_SVH
`define SCD_CFG_SVH

// Width of SCAD, FE and SC
`define SCD_WIDTH 10

// Width of the AR data word
`define AR_WIDTH 36

// Width of the microcode magic number field
`define MAGIC_WIDTH 9

`endif
